/* dm_ctrl_pkg.sv */
package dm_ctrl_pkg;

   // Descriptor control word
   localparam int dc_w = 24;              // Width of the descriptor word

   localparam int dc_go_bit   = 3;        // Start the selected operation
   localparam int dc_copy_bit = 5;        // Copy engine select
   localparam int dc_fill_bit = 6;        // Fill engine select

   localparam int dc_len_lsb = 8;         // Fill length, in words
   localparam int dc_len_msb = 23;

   // Engine state, shared by the copy and fill engines
   typedef enum logic [1:0] {
      s_idle = 2'b00,                     // Waiting for start
      s_run  = 2'b01,                     // Moving words
      s_wait = 2'b10,                     // Stalled on empty or full
      s_end  = 2'b11                      // Finished, held until go falls
   } eng_state_t;

endpackage

/* dm_data_pkg.sv */
package dm_data_pkg;

   // Payload word carried by both FIFOs, plus a separate last flag
   localparam int data_w = 64;

   // Depth used when the top level does not override it
   localparam int fifo_depth_default = 16;

   // Fill length counter, matches the dc length field
   localparam int len_w = 16;

endpackage

/* dm_fifo.sv */
`timescale 1ns/10ps

module dm_fifo
   import dm_data_pkg::*;
#(
   parameter int data_w_p = data_w,
   parameter int depth_p  = fifo_depth_default
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                put,
   input  logic [data_w_p-1:0] put_data,
   input  logic                put_last,
   input  logic                get,
   output logic [data_w_p-1:0] get_data,
   output logic                get_last,
   output logic                full,
   output logic                empty
);

   localparam int aw = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cw = $clog2(depth_p + 1);

   logic [data_w_p:0] mem [depth_p];      // {last, data}
   logic [aw-1:0]     wr_ptr;
   logic [aw-1:0]     rd_ptr;
   logic [cw-1:0]     count;
   logic              do_put;
   logic              do_get;

   assign do_put = put && !full;          // Never overwrite a full buffer
   assign do_get = get && !empty;

   assign full  = (count == cw'(depth_p));
   assign empty = (count == '0);

   // Show-ahead: the head word is always on the read side
   assign {get_last, get_data} = mem[rd_ptr];

   always_ff @(posedge wb_clk_i) begin
      if (do_put) begin
         mem[wr_ptr] <= {put_last, put_data};
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_put) begin
            wr_ptr <= (wr_ptr == aw'(depth_p - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_get) begin
            rd_ptr <= (rd_ptr == aw'(depth_p - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_put, do_get})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Both or neither, level unchanged
         endcase
      end
   end

endmodule

/* dm_copy.sv */
`timescale 1ns/10ps

module dm_copy
   import dm_data_pkg::*;
   import dm_ctrl_pkg::*;
#(
   parameter int data_w_p = data_w
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                start,
   input  logic                src_empty,
   input  logic [data_w_p-1:0] src_data,
   input  logic                src_last,
   output logic                src_get,
   input  logic                dst_full,
   output logic                dst_put,
   output logic [data_w_p-1:0] dst_data,
   output logic                dst_last,
   output logic                busy_end
);

   eng_state_t state;
   eng_state_t state_nxt;
   logic       xfer;

   // One word per edge, only when both sides can take it
   assign xfer = (state == s_run) && !src_empty && !dst_full;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= s_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         s_idle: begin
            if (start) state_nxt = s_run;
         end
         s_run: begin
            if (xfer && src_last) begin
               state_nxt = s_end;         // Last word of the packet moved
            end else if (src_empty || dst_full) begin
               state_nxt = s_wait;
            end
         end
         s_wait: begin
            if (!src_empty && !dst_full) state_nxt = s_run;
         end
         s_end: begin
            if (!start) state_nxt = s_idle;   // Host dropped go
         end
         default: state_nxt = s_idle;
      endcase
   end

   assign src_get  = xfer;
   assign dst_put  = xfer;
   assign dst_data = src_data;            // Head word passes straight through
   assign dst_last = src_last;
   assign busy_end = (state == s_end);

endmodule

/* dm_fill.sv */
`timescale 1ns/10ps

module dm_fill
   import dm_data_pkg::*;
   import dm_ctrl_pkg::*;
#(
   parameter int data_w_p = data_w
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                start,
   input  logic [len_w-1:0]    len,
   input  logic [data_w_p-1:0] pattern,
   input  logic                dst_full,
   output logic                dst_put,
   output logic [data_w_p-1:0] dst_data,
   output logic                dst_last,
   output logic                busy_end
);

   eng_state_t       state;
   eng_state_t       state_nxt;
   logic [len_w-1:0] cnt;                 // Words still to write

   assign dst_put = (state == s_run) && !dst_full;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= s_idle;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         if (state == s_idle && start) begin
            cnt <= len;
         end else if (dst_put) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         s_idle: begin
            if (start) begin
               state_nxt = (len == '0) ? s_end : s_run;   // Zero length writes nothing
            end
         end
         s_run: begin
            if (dst_put && cnt == len_w'(1)) state_nxt = s_end;
         end
         s_end: begin
            if (!start) state_nxt = s_idle;
         end
         default: state_nxt = s_idle;     // Fill never stalls in s_wait
      endcase
   end

   assign dst_data = pattern;
   assign dst_last = (cnt == len_w'(1));  // Final word of the run
   assign busy_end = (state == s_end);

endmodule

/* dm_op_ctrl.sv */
`timescale 1ns/10ps

module dm_op_ctrl
   import dm_data_pkg::*;
   import dm_ctrl_pkg::*;
#(
   parameter int data_w_p = data_w
) (
   input  logic [dc_w-1:0]     dc,
   output logic                copy_start,
   output logic                fill_start,
   output logic [len_w-1:0]    fill_len,
   input  logic                copy_put,
   input  logic [data_w_p-1:0] copy_data,
   input  logic                copy_last,
   input  logic                fill_put,
   input  logic [data_w_p-1:0] fill_data,
   input  logic                fill_last,
   input  logic                copy_end,
   input  logic                fill_end,
   output logic                dst_put,
   output logic [data_w_p-1:0] dst_data,
   output logic                dst_last,
   output logic                done
);

   logic go;
   logic copy_sel;
   logic fill_sel;

   assign go = dc[dc_go_bit];

   // Exactly one select bit must be set, two at once select nothing
   assign copy_sel = dc[dc_copy_bit] && !dc[dc_fill_bit];
   assign fill_sel = dc[dc_fill_bit] && !dc[dc_copy_bit];

   assign copy_start = go && copy_sel;
   assign fill_start = go && fill_sel;

   assign fill_len = dc[dc_len_msb:dc_len_lsb];

   // Destination FIFO write port follows the selected engine
   always_comb begin
      if (copy_sel) begin
         dst_put  = copy_put;
         dst_data = copy_data;
         dst_last = copy_last;
      end else if (fill_sel) begin
         dst_put  = fill_put;
         dst_data = fill_data;
         dst_last = fill_last;
      end else begin
         dst_put  = 1'b0;                 // No engine owns the FIFO
         dst_data = '0;
         dst_last = 1'b0;
      end
   end

   // Completion of whichever engine the descriptor names
   assign done = (copy_sel && copy_end) || (fill_sel && fill_end);

endmodule

/* dm_top.sv */
`timescale 1ns/10ps

module dm_top
   import dm_data_pkg::*;
   import dm_ctrl_pkg::*;
#(
   parameter int data_w_p = data_w,
   parameter int depth_p  = fifo_depth_default
) (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic [dc_w-1:0]     dc,
   input  logic [data_w_p-1:0] fill_value,
   input  logic [data_w_p-1:0] in_data,
   input  logic                in_last,
   input  logic                in_valid,
   output logic                in_ready,
   output logic [data_w_p-1:0] out_data,
   output logic                out_last,
   output logic                out_valid,
   input  logic                out_ready,
   output logic                done
);

   logic                src_put;
   logic                src_get;
   logic                src_full;
   logic                src_empty;
   logic [data_w_p-1:0] src_data;
   logic                src_last;

   logic                dst_put;
   logic                dst_get;
   logic                dst_full;
   logic                dst_empty;
   logic [data_w_p-1:0] dst_data;
   logic                dst_last;

   logic                copy_start;
   logic                copy_put;
   logic [data_w_p-1:0] copy_data;
   logic                copy_last;
   logic                copy_end;

   logic                fill_start;
   logic [len_w-1:0]    fill_len;
   logic                fill_put;
   logic [data_w_p-1:0] fill_data;
   logic                fill_last;
   logic                fill_end;

   // Valid/ready pairs become put/get strobes against full/empty
   assign in_ready  = !src_full;
   assign src_put   = in_valid && in_ready;
   assign out_valid = !dst_empty;
   assign dst_get   = out_ready && out_valid;

   dm_fifo #(.data_w_p(data_w_p), .depth_p(depth_p)) u_src_fifo (
      .wb_clk_i, .wb_rst_i,
      .put(src_put), .put_data(in_data), .put_last(in_last),
      .get(src_get), .get_data(src_data), .get_last(src_last),
      .full(src_full), .empty(src_empty)
   );

   dm_copy #(.data_w_p(data_w_p)) u_copy (
      .wb_clk_i, .wb_rst_i, .start(copy_start),
      .src_empty, .src_data, .src_last, .src_get, .dst_full,
      .dst_put(copy_put), .dst_data(copy_data), .dst_last(copy_last),
      .busy_end(copy_end)
   );

   dm_fill #(.data_w_p(data_w_p)) u_fill (
      .wb_clk_i, .wb_rst_i, .start(fill_start), .len(fill_len),
      .pattern(fill_value), .dst_full,
      .dst_put(fill_put), .dst_data(fill_data), .dst_last(fill_last),
      .busy_end(fill_end)
   );

   dm_op_ctrl #(.data_w_p(data_w_p)) u_op_ctrl (
      .dc, .copy_start, .fill_start, .fill_len,
      .copy_put, .copy_data, .copy_last, .fill_put, .fill_data, .fill_last,
      .copy_end, .fill_end, .dst_put, .dst_data, .dst_last, .done
   );

   dm_fifo #(.data_w_p(data_w_p), .depth_p(depth_p)) u_dst_fifo (
      .wb_clk_i, .wb_rst_i,
      .put(dst_put), .put_data(dst_data), .put_last(dst_last),
      .get(dst_get), .get_data(out_data), .get_last(out_last),
      .full(dst_full), .empty(dst_empty)
   );

endmodule

/* dm_tb_tasks.svh */
// Sends one copy packet, then compares the output with what was sent
task automatic copy_packet(input string test, input int n_words, input bit gaps);
   logic [data_w-1:0] word;
   logic [31:0]       rnd;
   exp_q.delete();
   out_q.delete();
   last_q.delete();
   start_op(1'b1, 1'b0, '0);
   for (int i = 0; i < n_words; i++) begin
      word = random_word();
      exp_q.push_back(word);
      push_word(test, word, i == n_words - 1);
      if (gaps) begin
         rnd = $random(seed);
         wait_cycles(int'(rnd[1:0]));     // Idle input cycles
         if (i == 4) wait_cycles(12);     // Source FIFO runs dry mid-packet
      end
   end
   wait_done_level(test, 1'b1, done_timeout);
   wait_for_words(test, n_words);
   check_value(test, "word count", data_w'(n_words), data_w'(out_q.size()));
   for (int i = 0; i < out_q.size() && i < n_words; i++) begin
      check_value(test, $sformatf("word %0d", i), exp_q[i], out_q[i]);
      check_value(test, $sformatf("last %0d", i), data_w'(i == n_words - 1),
                  data_w'(last_q[i]));
   end
endtask

task automatic check_reset_state();
   int errors_before;
   errors_before = errors;
   check_value("reset_state", "out_valid", '0, data_w'(out_valid));
   check_value("reset_state", "done", '0, data_w'(done));
   check_value("reset_state", "in_ready", data_w'(1), data_w'(in_ready));
   finish_test("reset_state", errors_before);
endtask

task automatic copy_in_order();
   int errors_before;
   errors_before = errors;
   ready_random = 1'b0;
   copy_packet("copy_in_order", 10, 1'b0);
   end_operation("copy_in_order");
   finish_test("copy_in_order", errors_before);
endtask

task automatic copy_under_backpressure();
   int errors_before;
   errors_before = errors;
   ready_random = 1'b1;                   // Output slower than input, both FIFOs fill
   copy_packet("copy_backpressure", 40, 1'b1);
   end_operation("copy_backpressure");
   ready_random = 1'b0;
   finish_test("copy_backpressure", errors_before);
endtask

task automatic fill_pattern_and_empty();
   int errors_before;
   errors_before = errors;
   out_q.delete();
   last_q.delete();
   fill_value = fill_pattern;
   start_op(1'b0, 1'b1, 16'd7);
   wait_done_level("fill_7", 1'b1, done_timeout);
   wait_for_words("fill_7", 7);
   check_value("fill_7", "word count", data_w'(7), data_w'(out_q.size()));
   foreach (out_q[i]) begin
      check_value("fill_7", $sformatf("word %0d", i), fill_pattern, out_q[i]);
      check_value("fill_7", $sformatf("last %0d", i), data_w'(i == 6), data_w'(last_q[i]));
   end
   end_operation("fill_7");
   // Zero length ends at once and writes nothing
   out_q.delete();
   start_op(1'b0, 1'b1, '0);
   wait_done_level("fill_0", 1'b1, done_timeout);
   wait_cycles(4);
   check_value("fill_0", "word count", '0, data_w'(out_q.size()));
   check_value("fill_0", "out_valid", '0, data_w'(out_valid));
   end_operation("fill_0");
   finish_test("fill", errors_before);
endtask

task automatic done_holds_until_go_drops();
   int errors_before;
   errors_before = errors;
   copy_packet("done_hold", 4, 1'b0);
   for (int i = 0; i < 20; i++) begin
      check_value("done_hold", "done while go held", data_w'(1), data_w'(done));
      wait_cycles(1);
   end
   dc[dc_go_bit] = 1'b0;
   wait_done_level("done_hold", 1'b0, 4);
   dc = '0;
   wait_cycles(1);
   copy_packet("copy_after_done", 6, 1'b0);
   end_operation("copy_after_done");
   finish_test("done_hold", errors_before);
endtask

task automatic reject_double_select();
   int errors_before;
   errors_before = errors;
   out_q.delete();
   start_op(1'b1, 1'b1, 16'd3);           // A wrongly started fill would show words too
   for (int i = 0; i < 3; i++) begin
      push_word("double_select", random_word(), i == 2);
   end
   for (int i = 0; i < 50 && !done; i++) begin
      wait_cycles(1);
   end
   check_value("double_select", "done", '0, data_w'(done));
   check_value("double_select", "output words", '0, data_w'(out_q.size()));
   dc = '0;
   wait_cycles(1);
   finish_test("double_select", errors_before);
endtask

/* dm_tb.sv */
`timescale 1ns/10ps

module dm_tb
   import dm_data_pkg::*;
   import dm_ctrl_pkg::*;
();

   localparam int done_timeout  = 2000;   // Cycles allowed per wait
   localparam int ready_timeout = 500;
   localparam logic [data_w-1:0] fill_pattern = 64'hc3a5_0f96_5a3c_e187;

   logic              wb_clk_i;
   logic              wb_rst_i;
   logic [dc_w-1:0]   dc;
   logic [data_w-1:0] fill_value;
   logic [data_w-1:0] in_data;
   logic              in_last;
   logic              in_valid;
   logic              in_ready;
   logic [data_w-1:0] out_data;
   logic              out_last;
   logic              out_valid;
   logic              out_ready;
   logic              done;

   integer            seed = 32'hd118_e758;
   bit                ready_random;       // Random out_ready instead of held high
   int                errors;
   int                tests_run;
   int                tests_failed;
   logic [data_w-1:0] exp_q [$];          // Words sent into the source side
   logic [data_w-1:0] out_q [$];          // Every word accepted on the output
   bit                last_q [$];

   dm_top #(.data_w_p(data_w), .depth_p(fifo_depth_default)) u_dm_top (
      .wb_clk_i, .wb_rst_i, .dc, .fill_value,
      .in_data, .in_last, .in_valid, .in_ready,
      .out_data, .out_last, .out_valid, .out_ready, .done
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #2 wb_clk_i = ~wb_clk_i;
   end

   always @(posedge wb_clk_i) begin
      if (!wb_rst_i && out_valid && out_ready) begin
         out_q.push_back(out_data);
         last_q.push_back(out_last);
      end
   end

   // Output back-pressure with ready about one cycle in four when random
   initial begin
      logic [31:0] rnd;
      logic        ready_nxt;
      out_ready = 1'b0;
      forever begin
         @(posedge wb_clk_i);
         rnd = $random(seed);             // Drawn on the edge, apart from the test's draws
         ready_nxt = ready_random ? (rnd[1:0] == 2'b00) : !wb_rst_i;
         #1;
         out_ready = ready_nxt;
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge wb_clk_i);
         #1;                              // Drive point after the edge
      end
   endtask

   function automatic logic [data_w-1:0] random_word();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic check_value(input string test, input string what,
                              input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
      assert (act == exp) else begin
         $display("FAIL %s: %s expected %h actual %h", test, what, exp, act);
         errors++;
      end
   endtask

   task automatic wait_done_level(input string test, input logic level, input int limit);
      int n;
      n = 0;
      while (done !== level && n < limit) begin
         wait_cycles(1);
         n++;
      end
      assert (done === level) else begin
         $display("%s: done did not go to %0b within %0d cycles", test, level, limit);
         errors++;
      end
   endtask

   // Offers one word and holds it until the source FIFO takes it
   task automatic push_word(input string test, input logic [data_w-1:0] data,
                            input logic last);
      int n;
      n = 0;
      in_data  = data;
      in_last  = last;
      in_valid = 1'b1;
      while (!in_ready && n < ready_timeout) begin
         wait_cycles(1);
         n++;
      end
      assert (in_ready) else begin
         $display("%s: in_ready stayed low for %0d cycles", test, ready_timeout);
         errors++;
      end
      wait_cycles(1);
      in_valid = 1'b0;
   endtask

   // Collects output until the expected count is reached and the output FIFO is empty
   task automatic wait_for_words(input string test, input int count);
      int n;
      n = 0;
      while ((out_q.size() < count || out_valid) && n < done_timeout) begin
         wait_cycles(1);
         n++;
      end
      assert (out_q.size() >= count) else begin
         $display("%s: only %0d of %0d output words arrived", test, out_q.size(), count);
         errors++;
      end
      assert (!out_valid) else begin
         $display("%s: output FIFO did not drain within %0d cycles", test, done_timeout);
         errors++;
      end
   endtask

   task automatic start_op(input bit copy, input bit fill, input logic [len_w-1:0] len);
      dc = '0;
      dc[dc_copy_bit] = copy;
      dc[dc_fill_bit] = fill;
      dc[dc_len_msb:dc_len_lsb] = len;
      dc[dc_go_bit] = 1'b1;
   endtask

   task automatic end_operation(input string test);
      dc[dc_go_bit] = 1'b0;
      wait_done_level(test, 1'b0, 8);
      dc = '0;
      wait_cycles(1);
   endtask

   task automatic finish_test(input string test, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("%s: ok", test);
      end else begin
         tests_failed++;
         $display("%s: %0d error(s)", test, errors - errors_before);
      end
   endtask

   `include "dm_tb_tasks.svh"

   initial begin
      wb_rst_i     = 1'b1;
      dc           = '0;
      fill_value   = '0;
      in_data      = '0;
      in_last      = 1'b0;
      in_valid     = 1'b0;
      ready_random = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      wait_cycles(10);
      wb_rst_i = 1'b0;
      wait_cycles(1);
      check_reset_state();
      copy_in_order();
      copy_under_backpressure();
      fill_pattern_and_empty();
      done_holds_until_go_drops();
      reject_double_select();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* dm.f */
+incdir+.
dm_ctrl_pkg.sv
dm_data_pkg.sv
dm_fifo.sv
dm_copy.sv
dm_fill.sv
dm_op_ctrl.sv
dm_top.sv
dm_tb.sv

/* Makefile */
# Verilator build and run of the data mover testbench
TOP = dm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f dm.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed, see sim.log"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "No pass line in sim.log"; exit 1)

# Lint the RTL, every warning is reported
lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f dm.f --top-module dm_top

clean:
	rm -rf obj_dir sim.log
